// ==== design/loader_pkg.sv ====
//======================================
// Loader package
// Shared widths, FSM states, file indices
// and fixed page-zero addresses
//======================================
package loader_pkg;

	// Data and address widths
	typedef logic [7:0]  byte_t;       // Downloaded or written byte
	typedef logic [15:0] word_t;       // 16-bit header field
	typedef logic [24:0] mem_addr_t;   // System memory byte address
	typedef logic [24:0] dl_offset_t;  // Offset within the download
	typedef logic [7:0]  dl_index_t;   // Host file index
	typedef logic [31:0] blk_len_t;    // Chip packet length

	// Program loader FSM
	typedef enum logic [1:0] {
		PRG_IDLE,
		PRG_LOAD,
		PRG_INIT,
		PRG_WAIT
	} prg_state_e;

	// Cartridge loader FSM
	typedef enum logic [1:0] {
		CRT_FILE_HDR,
		CRT_CHIP_HDR,
		CRT_DATA
	} crt_state_e;

	// File indices from the host
	localparam dl_index_t IDX_PRG = 8'd4;
	localparam dl_index_t IDX_CRT = 8'd5;

	// Interpreter pointer range in page zero
	localparam byte_t PTR_FIRST = 8'h2B;
	localparam byte_t PTR_LAST  = 8'hAF;

	//======================================
	// Cartridge file layout
	//======================================
	localparam blk_len_t   CHIP_HDR_LEN = 32'd16;   // Bytes per chip header
	localparam dl_offset_t CRT_DATA_OFS = 25'h40;   // First chip packet

	// Cartridge header field offsets
	localparam dl_offset_t OFS_ID_HI = 25'h16;
	localparam dl_offset_t OFS_ID_LO = 25'h17;
	localparam dl_offset_t OFS_EXROM = 25'h18;
	localparam dl_offset_t OFS_GAME  = 25'h19;

endpackage

// ==== design/mem_write_port.sv ====
//======================================
// Memory slot writer
// Holds one write and issues it in the
// loader slot after io_cycle falls
//======================================
module mem_write_port
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      prg_req_i,
	input  logic      crt_req_i,
	input  mem_addr_t prg_addr_i,
	input  mem_addr_t crt_addr_i,
	input  byte_t     prg_data_i,
	input  byte_t     crt_data_i,
	input  logic      io_cycle_i,
	output logic      busy_o,
	output logic      mem_ce_o,
	output logic      mem_we_o,
	output mem_addr_t mem_addr_o,
	output byte_t     mem_data_o
);

	logic      hold_valid;
	mem_addr_t hold_addr;
	byte_t     hold_data;
	logic      io_cycle_d;
	logic      req_any;
	logic      slot_open;
	logic      issue;

	assign req_any   = prg_req_i | crt_req_i;
	assign slot_open = io_cycle_d & ~io_cycle_i;   // System just released memory
	assign issue     = hold_valid & slot_open;

	// A request in flight already stalls the host, so the next strobe waits
	assign busy_o = hold_valid | req_any;

	// Holder state and write strobes
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			hold_valid <= 1'b0;
			mem_ce_o   <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			mem_ce_o   <= issue;
			mem_we_o   <= issue;
			if (issue)
				hold_valid <= 1'b0;
			else if (!hold_valid && req_any)
				hold_valid <= 1'b1;
		end
	end

	// Held write, program loader first
	always_ff @(posedge clk_sys) begin
		if (!hold_valid) begin
			if (prg_req_i) begin
				hold_addr <= prg_addr_i;
				hold_data <= prg_data_i;
			end else if (crt_req_i) begin
				hold_addr <= crt_addr_i;
				hold_data <= crt_data_i;
			end
		end
		if (issue) begin
			mem_addr_o <= hold_addr;
			mem_data_o <= hold_data;
		end
	end

endmodule

// ==== design/prg_loader.sv ====
//======================================
// Program loader
// Load address decode, data writes and
// interpreter pointer setup after load
//======================================
module prg_loader
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  dl_index_t  dl_index_i,
	input  dl_offset_t dl_offset_i,
	input  byte_t      dl_data_i,
	input  logic       dl_wr_i,
	input  logic       busy_i,
	output logic       req_o,
	output mem_addr_t  addr_o,
	output byte_t      data_o
);

	prg_state_e state;
	word_t      load_addr;   // Next write address, end address once loaded
	byte_t      ptr;         // Page-zero walk position
	logic       is_prg;
	logic       byte_ok;
	logic       data_wr;
	logic       init_wr;
	logic       ptr_hit;
	byte_t      ptr_val;

	assign is_prg  = (dl_index_i == IDX_PRG);
	assign byte_ok = dl_wr_i && dl_active_i && is_prg;
	assign data_wr = byte_ok && (dl_offset_i >= 25'd2);
	assign init_wr = (state == PRG_INIT) && ptr_hit && !busy_i;

	// Pointer values as a LOAD command leaves them
	always_comb begin
		ptr_hit = 1'b1;
		ptr_val = 8'h00;
		case (ptr)
			8'h2B: ptr_val = 8'h01;                  // Text start low
			8'h2C: ptr_val = 8'h08;                  // Text start high
			8'hAC, 8'hAD: ptr_val = 8'h00;
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_val = load_addr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_val = load_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	//======================================
	// Control FSM
	//======================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state <= PRG_IDLE;
			req_o <= 1'b0;
		end else begin
			req_o <= data_wr | init_wr;
			case (state)
				PRG_IDLE: if (dl_active_i && is_prg) state <= PRG_LOAD;
				PRG_LOAD: if (!dl_active_i) state <= PRG_INIT;
				PRG_INIT: if (init_wr) state <= PRG_WAIT;
				PRG_WAIT: begin
					// Wait for the pointer write to leave the port
					if (!busy_i)
						state <= (ptr == PTR_LAST) ? PRG_IDLE : PRG_INIT;
				end
				default: state <= PRG_IDLE;
			endcase
		end
	end

	// Address counters and request payload
	always_ff @(posedge clk_sys) begin
		if (byte_ok && dl_offset_i == 25'd0)
			load_addr[7:0] <= dl_data_i;
		else if (byte_ok && dl_offset_i == 25'd1)
			load_addr[15:8] <= dl_data_i;
		else if (data_wr)
			load_addr <= load_addr + 16'd1;

		if (state == PRG_LOAD && !dl_active_i)
			ptr <= PTR_FIRST;
		else if (state == PRG_INIT && !ptr_hit)
			ptr <= ptr + 8'd1;              // Skip unrelated page-zero bytes
		else if (state == PRG_WAIT && !busy_i && ptr != PTR_LAST)
			ptr <= ptr + 8'd1;

		if (init_wr) begin
			addr_o <= mem_addr_t'(ptr);
			data_o <= ptr_val;
		end else if (data_wr) begin
			addr_o <= mem_addr_t'(load_addr);
			data_o <= dl_data_i;
		end
	end

endmodule

// ==== design/crt_loader.sv ====
//======================================
// Cartridge loader
// File and chip header decode, bank
// records and chip data writes
//======================================
module crt_loader
	import loader_pkg::*;
#(
	parameter mem_addr_t CRT_BASE = 25'h0100000
) (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  dl_index_t  dl_index_i,
	input  dl_offset_t dl_offset_i,
	input  byte_t      dl_data_i,
	input  logic       dl_wr_i,
	output logic       req_o,
	output mem_addr_t  addr_o,
	output byte_t      data_o,
	output word_t      cart_id_o,
	output byte_t      cart_exrom_o,
	output byte_t      cart_game_o,
	output logic       cart_attached_o,
	output logic       bank_valid_o,
	output byte_t      bank_type_o,
	output word_t      bank_num_o,
	output word_t      bank_laddr_o,
	output word_t      bank_size_o
);

	localparam logic [3:0] HDR_LAST = 4'(CHIP_HDR_LEN - 1);

	crt_state_e state;
	mem_addr_t  load_addr;
	blk_len_t   blk_len;      // Data bytes left in the chip packet
	logic [3:0] hdr_cnt;
	logic       first_chip;
	logic       active_d;     // Cartridge download active, delayed
	logic       is_crt;
	logic       byte_ok;
	logic       restart;

	assign is_crt  = (dl_index_i == IDX_CRT);
	assign byte_ok = dl_wr_i && dl_active_i && is_crt;
	assign restart = byte_ok && (dl_offset_i == '0);

	//======================================
	// Control FSM
	//======================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= CRT_FILE_HDR;
			hdr_cnt         <= '0;
			first_chip      <= 1'b1;
			active_d        <= 1'b0;
			req_o           <= 1'b0;
			bank_valid_o    <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			req_o        <= 1'b0;
			bank_valid_o <= 1'b0;
			active_d     <= dl_active_i && is_crt;
			if (dl_active_i && is_crt && !active_d)
				cart_attached_o <= 1'b0;            // New cartridge coming in
			else if (active_d && !dl_active_i)
				cart_attached_o <= 1'b1;

			if (restart) begin
				state      <= CRT_FILE_HDR;
				hdr_cnt    <= '0;
				first_chip <= 1'b1;
			end else if (byte_ok) begin
				case (state)
					CRT_FILE_HDR: if (dl_offset_i == CRT_DATA_OFS - 1) state <= CRT_CHIP_HDR;
					CRT_CHIP_HDR: begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == 4'd0)
							first_chip <= 1'b0;
						if (hdr_cnt == HDR_LAST) begin
							bank_valid_o <= 1'b1;
							if (blk_len != '0) state <= CRT_DATA;   // Empty chips carry no data
						end
					end
					CRT_DATA: begin
						req_o <= 1'b1;
						if (blk_len == blk_len_t'(1)) state <= CRT_CHIP_HDR;
					end
					default: state <= CRT_FILE_HDR;
				endcase
			end
		end
	end

	// Header fields, bank record and data payload
	always_ff @(posedge clk_sys) begin
		if (restart) begin
			load_addr <= CRT_BASE;
		end else if (byte_ok) begin
			case (state)
				CRT_FILE_HDR: begin
					if (dl_offset_i == OFS_ID_HI) cart_id_o[15:8] <= dl_data_i;
					if (dl_offset_i == OFS_ID_LO) cart_id_o[7:0]  <= dl_data_i;
					if (dl_offset_i == OFS_EXROM) cart_exrom_o    <= dl_data_i;
					if (dl_offset_i == OFS_GAME)  cart_game_o     <= dl_data_i;
				end
				CRT_CHIP_HDR: begin
					case (hdr_cnt)
						4'd0: begin
							// Align the first chip to an 8 KB bank
							if (first_chip && load_addr[12:0] != '0)
								load_addr <= {load_addr[24:13] + 12'd1, 13'd0};
						end
						4'd4:  blk_len[31:24]     <= dl_data_i;
						4'd5:  blk_len[23:16]     <= dl_data_i;
						4'd6:  blk_len[15:8]      <= dl_data_i;
						4'd7:  blk_len[7:0]       <= dl_data_i;
						4'd8:  blk_len            <= blk_len - CHIP_HDR_LEN;
						4'd9:  bank_type_o        <= dl_data_i;
						4'd10: bank_num_o[15:8]   <= dl_data_i;
						4'd11: bank_num_o[7:0]    <= dl_data_i;
						4'd12: bank_laddr_o[15:8] <= dl_data_i;
						4'd13: bank_laddr_o[7:0]  <= dl_data_i;
						4'd14: bank_size_o[15:8]  <= dl_data_i;
						4'd15: bank_size_o[7:0]   <= dl_data_i;
						default: ;
					endcase
				end
				CRT_DATA: begin
					addr_o    <= load_addr;
					data_o    <= dl_data_i;
					load_addr <= load_addr + 25'd1;
					blk_len   <= blk_len - 32'd1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== design/loader_top.sv ====
//======================================
// Loader top level
// Program and cartridge loaders sharing
// one memory slot writer
//======================================
module loader_top
	import loader_pkg::*;
#(
	parameter mem_addr_t CRT_BASE = 25'h0100000
) (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  dl_index_t  dl_index_i,
	input  dl_offset_t dl_offset_i,
	input  byte_t      dl_data_i,
	input  logic       dl_wr_i,
	input  logic       io_cycle_i,
	output logic       wait_o,
	output logic       mem_ce_o,
	output logic       mem_we_o,
	output mem_addr_t  mem_addr_o,
	output byte_t      mem_data_o,
	output word_t      cart_id_o,
	output byte_t      cart_exrom_o,
	output byte_t      cart_game_o,
	output logic       cart_attached_o,
	output logic       bank_valid_o,
	output byte_t      bank_type_o,
	output word_t      bank_num_o,
	output word_t      bank_laddr_o,
	output word_t      bank_size_o
);

	logic      busy;
	logic      prg_req;
	mem_addr_t prg_addr;
	byte_t     prg_data;
	logic      crt_req;
	mem_addr_t crt_addr;
	byte_t     crt_data;

	assign wait_o = busy;   // Host back-pressure

	prg_loader u_prg_loader (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_offset_i (dl_offset_i),
		.dl_data_i   (dl_data_i),
		.dl_wr_i     (dl_wr_i),
		.busy_i      (busy),
		.req_o       (prg_req),
		.addr_o      (prg_addr),
		.data_o      (prg_data)
	);

	crt_loader #(
		.CRT_BASE (CRT_BASE)
	) u_crt_loader (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_offset_i     (dl_offset_i),
		.dl_data_i       (dl_data_i),
		.dl_wr_i         (dl_wr_i),
		.req_o           (crt_req),
		.addr_o          (crt_addr),
		.data_o          (crt_data),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o),
		.bank_valid_o    (bank_valid_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o)
	);

	mem_write_port u_mem_write_port (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.prg_req_i  (prg_req),
		.crt_req_i  (crt_req),
		.prg_addr_i (prg_addr),
		.crt_addr_i (crt_addr),
		.prg_data_i (prg_data),
		.crt_data_i (crt_data),
		.io_cycle_i (io_cycle_i),
		.busy_o     (busy),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

// ==== test/tb_clock.sv ====
//======================================
// Testbench clock and reset
//======================================
module tb_clock #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_sys,
	output logic reset_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Reset released on a falling edge, away from the sampling edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset_n = 1'b1;
	end

endmodule

// ==== test/loader_sva.sv ====
//======================================
// Slot writer assertions
// Write strobe shape and slot timing
//======================================
module loader_sva (
	input logic clk_sys,
	input logic reset_n,
	input logic io_cycle_i,
	input logic busy_i,
	input logic mem_ce_i,
	input logic mem_we_i
);

	int unsigned sva_fails = 0;   // Assertion failures so far

	a_ce_one_cycle: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_ce_i |=> !mem_ce_i)
	else begin
		sva_fails++;
		$error("mem_ce_o high for more than one cycle");
	end

	a_we_is_ce: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_i == mem_ce_i)
	else begin
		sva_fails++;
		$error("mem_we_o differs from mem_ce_o");
	end

	// Write sits in the cycle right after io_cycle fell
	a_write_after_fall: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_ce_i |-> $past(io_cycle_i, 2) && !$past(io_cycle_i))
	else begin
		sva_fails++;
		$error("write issued without a falling edge of io_cycle_i");
	end

	// Busy held up to the write and dropped as it leaves
	a_busy_before_write: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_ce_i |-> $past(busy_i) && !busy_i)
	else begin
		sva_fails++;
		$error("busy not high before the write or not low during it");
	end

endmodule

bind mem_write_port loader_sva u_loader_sva (
	.clk_sys    (clk_sys),
	.reset_n    (reset_n),
	.io_cycle_i (io_cycle_i),
	.busy_i     (busy_o),
	.mem_ce_i   (mem_ce_o),
	.mem_we_i   (mem_we_o)
);

// ==== test/tb_top.sv ====
//======================================
// Loader testbench
// Directed program and cartridge tests
// against a memory model and slot source
//======================================
module tb_top
	import loader_pkg::*;
;

	localparam int        CLK_PERIOD = 4;
	localparam int unsigned SEED     = 32'hb7a38d6d;
	localparam int        SLOT_MIN   = 6;
	localparam int        SLOT_MAX   = 20;
	localparam mem_addr_t CRT_BASE   = 25'h0100000;   // DUT default
	localparam word_t     LOAD_ADDR  = 16'h0801;
	localparam int        PRG_LEN    = 40;
	localparam word_t     BANK_LADDR = 16'h8000;
	localparam byte_t     CHIP_TYPE  = 8'h02;

	// Every downloaded byte plus the pointer writes
	localparam int TOTAL_BYTES = PRG_LEN + 12 + (64 + 16 + 8192)
		+ (64 + 2 * (16 + 256)) + (64 + 16 + 64);
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * SLOT_MAX * 4 + 2000;

	logic       clk_sys;
	logic       reset_n;
	logic       dl_active_i;
	dl_index_t  dl_index_i;
	dl_offset_t dl_offset_i;
	byte_t      dl_data_i;
	logic       dl_wr_i;
	logic       io_cycle_i;
	logic       wait_o;
	logic       mem_ce_o;
	logic       mem_we_o;
	mem_addr_t  mem_addr_o;
	byte_t      mem_data_o;
	word_t      cart_id_o;
	byte_t      cart_exrom_o;
	byte_t      cart_game_o;
	logic       cart_attached_o;
	logic       bank_valid_o;
	byte_t      bank_type_o;
	word_t      bank_num_o;
	word_t      bank_laddr_o;
	word_t      bank_size_o;

	byte_t      mem [mem_addr_t];   // Memory model
	mem_addr_t  log_addr [$];       // Writes in arrival order
	byte_t      log_data [$];
	int         bank_count = 0;
	byte_t      cap_type;
	word_t      cap_num;
	word_t      cap_laddr;
	word_t      cap_size;

	int         checks = 0;
	int         errors = 0;
	int         test_errors = 0;
	string      cur_test;
	dl_offset_t next_ofs;
	int         data_idx;
	int         prg_log_base;

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
		.clk_sys (clk_sys),
		.reset_n (reset_n)
	);

	loader_top dut0 (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_offset_i     (dl_offset_i),
		.dl_data_i       (dl_data_i),
		.dl_wr_i         (dl_wr_i),
		.io_cycle_i      (io_cycle_i),
		.wait_o          (wait_o),
		.mem_ce_o        (mem_ce_o),
		.mem_we_o        (mem_we_o),
		.mem_addr_o      (mem_addr_o),
		.mem_data_o      (mem_data_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o),
		.bank_valid_o    (bank_valid_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o)
	);

	//======================================
	// System slots, memory and bank capture
	//======================================
	initial begin : slot_gen
		int period;
		io_cycle_i = 1'b0;
		void'($urandom(SEED));
		forever begin
			period = SLOT_MIN + int'($urandom % (SLOT_MAX - SLOT_MIN + 1));
			io_cycle_i = 1'b1;               // System owns memory
			repeat (period / 2) @(negedge clk_sys);
			io_cycle_i = 1'b0;
			repeat (period - period / 2) @(negedge clk_sys);
		end
	end

	always @(negedge clk_sys) begin
		if (reset_n && mem_ce_o) begin
			check_bit("mem_we_o", mem_we_o, 1'b1);
			mem[mem_addr_o] = mem_data_o;
			log_addr.push_back(mem_addr_o);
			log_data.push_back(mem_data_o);
		end
		if (bank_valid_o) begin
			bank_count++;
			cap_type  = bank_type_o;
			cap_num   = bank_num_o;
			cap_laddr = bank_laddr_o;
			cap_size  = bank_size_o;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	//======================================
	// Checks and reporting
	//======================================
	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(string name, byte_t got, byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, mem_addr_t got, mem_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(string msg);
		errors++;
		test_errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	task automatic start_test(string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		$display("test %-14s %s (%0d errors)", cur_test,
			(test_errors == 0) ? "ok" : "bad", test_errors);
	endtask

	// Waits until the memory log holds count writes
	task automatic wait_log(int count);
		int budget;
		budget = (count - log_addr.size()) * SLOT_MAX * 4 + 100;
		while (log_addr.size() < count && budget > 0) begin
			@(negedge clk_sys);
			budget--;
		end
		if (log_addr.size() < count)
			report_failure($sformatf("only %0d of %0d writes reached memory",
				log_addr.size(), count));
	endtask

	//======================================
	// Expected data
	//======================================
	function automatic byte_t prg_byte(int n);
		return byte_t'(n * 5) ^ 8'h3C;
	endfunction

	function automatic byte_t crt_byte(int k, byte_t salt);
		return byte_t'(k) ^ byte_t'(k >> 8) ^ salt;
	endfunction

	// Page-zero values that a LOAD command leaves behind
	function automatic logic pointer_value(input byte_t a, input word_t end_addr,
		output byte_t val);
		val = 8'h00;
		case (a)
			8'h2B: val = 8'h01;
			8'h2C: val = 8'h08;
			8'hAC, 8'hAD: val = 8'h00;
			8'h2D, 8'h2F, 8'h31, 8'hAE: val = end_addr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: val = end_addr[15:8];
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	//======================================
	// Host download driver
	//======================================
	task automatic begin_download(dl_index_t index);
		dl_index_i  = index;
		dl_active_i = 1'b1;
		next_ofs    = '0;
		data_idx    = 0;
		@(negedge clk_sys);
	endtask

	task automatic stream_byte(byte_t data);
		while (wait_o) @(negedge clk_sys);   // Host held off
		dl_offset_i = next_ofs;
		dl_data_i   = data;
		dl_wr_i     = 1'b1;
		@(negedge clk_sys);
		dl_wr_i     = 1'b0;
		next_ofs    = next_ofs + 25'd1;
	endtask

	task automatic end_download();
		while (wait_o) @(negedge clk_sys);
		dl_active_i = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic send_crt_header(word_t id, byte_t exrom, byte_t game);
		int i;
		for (i = 0; i < 'h40; i++) begin
			case (i)
				'h16: stream_byte(id[15:8]);
				'h17: stream_byte(id[7:0]);
				'h18: stream_byte(exrom);
				'h19: stream_byte(game);
				default: stream_byte(8'h20);
			endcase
		end
	endtask

	task automatic send_chip(word_t bank, int len, byte_t salt);
		blk_len_t plen;
		word_t    size;
		int       i;
		plen = blk_len_t'(len) + 32'd16;   // Packet length counts its header
		size = word_t'(len);
		stream_byte(8'h43);
		stream_byte(8'h48);
		stream_byte(8'h49);
		stream_byte(8'h50);
		stream_byte(plen[31:24]);
		stream_byte(plen[23:16]);
		stream_byte(plen[15:8]);
		stream_byte(plen[7:0]);
		stream_byte(8'h00);
		stream_byte(CHIP_TYPE);
		stream_byte(bank[15:8]);
		stream_byte(bank[7:0]);
		stream_byte(BANK_LADDR[15:8]);
		stream_byte(BANK_LADDR[7:0]);
		stream_byte(size[15:8]);
		stream_byte(size[7:0]);
		for (i = 0; i < len; i++) begin
			stream_byte(crt_byte(data_idx, salt));
			data_idx++;
		end
	endtask

	task automatic check_crt_data(int base, int count, byte_t salt);
		int k;
		wait_log(base + count);
		if (log_addr.size() != base + count)
			report_failure($sformatf("expected %0d cartridge writes, saw %0d",
				count, log_addr.size() - base));
		for (k = 0; k < count && base + k < log_addr.size(); k++) begin
			check_addr($sformatf("mem_addr_o[%0d]", k), log_addr[base + k],
				CRT_BASE + mem_addr_t'(k));
			check_byte($sformatf("mem_data_o[%0d]", k), log_data[base + k],
				crt_byte(k, salt));
		end
	endtask

	//======================================
	// Directed tests
	//======================================
	task automatic test_reset();
		start_test("reset");
		check_bit("wait_o", wait_o, 1'b0);
		check_bit("mem_ce_o", mem_ce_o, 1'b0);
		check_bit("bank_valid_o", bank_valid_o, 1'b0);
		check_bit("cart_attached_o", cart_attached_o, 1'b0);
		finish_test();
	endtask

	task automatic test_prg_data();
		int n;
		start_test("prg_data");
		prg_log_base = log_addr.size();
		begin_download(IDX_PRG);
		stream_byte(LOAD_ADDR[7:0]);
		stream_byte(LOAD_ADDR[15:8]);
		for (n = 2; n < PRG_LEN; n++)
			stream_byte(prg_byte(n));
		end_download();
		wait_log(prg_log_base + PRG_LEN - 2);
		for (n = 2; n < PRG_LEN && prg_log_base + n - 2 < log_addr.size(); n++) begin
			check_addr($sformatf("mem_addr_o[%0d]", n), log_addr[prg_log_base + n - 2],
				mem_addr_t'(LOAD_ADDR) + mem_addr_t'(n - 2));
			check_byte($sformatf("mem_data_o[%0d]", n), log_data[prg_log_base + n - 2],
				prg_byte(n));
		end
		finish_test();
	endtask

	task automatic test_prg_pointers();
		word_t end_addr;
		byte_t val;
		int    a;
		int    n_ptr;
		int    idx;
		start_test("prg_pointers");
		end_addr = LOAD_ADDR + word_t'(PRG_LEN - 2);
		n_ptr    = 0;
		for (a = 0; a < 256; a++)
			if (pointer_value(byte_t'(a), end_addr, val)) n_ptr++;
		wait_log(prg_log_base + PRG_LEN - 2 + n_ptr);
		repeat (2 * SLOT_MAX) @(negedge clk_sys);   // Catch any stray write
		if (log_addr.size() != prg_log_base + PRG_LEN - 2 + n_ptr)
			report_failure($sformatf("expected %0d program writes, saw %0d",
				PRG_LEN - 2 + n_ptr, log_addr.size() - prg_log_base));
		idx = prg_log_base + PRG_LEN - 2;
		for (a = 0; a < 256; a++) begin
			if (pointer_value(byte_t'(a), end_addr, val)) begin
				if (idx < log_addr.size()) begin
					check_addr($sformatf("ptr_addr[%02h]", a), log_addr[idx], mem_addr_t'(a));
					check_byte($sformatf("ptr_data[%02h]", a), log_data[idx], val);
				end
				idx++;
			end else if (mem.exists(mem_addr_t'(a))) begin
				report_failure($sformatf("page-zero byte %02h was written", a));
			end
		end
		finish_test();
	endtask

	task automatic test_crt_header();
		int base;
		int banks;
		start_test("crt_header");
		base  = log_addr.size();
		banks = bank_count;
		begin_download(IDX_CRT);
		send_crt_header(16'h0020, 8'h01, 8'h00);
		send_chip(16'd0, 8192, 8'h5A);
		end_download();
		check_bit("cart_attached_o", cart_attached_o, 1'b1);
		check_word("cart_id_o", cart_id_o, 16'h0020);
		check_byte("cart_exrom_o", cart_exrom_o, 8'h01);
		check_byte("cart_game_o", cart_game_o, 8'h00);
		if (bank_count != banks + 1)
			report_failure($sformatf("saw %0d bank records instead of one",
				bank_count - banks));
		check_byte("bank_type_o", cap_type, CHIP_TYPE);
		check_word("bank_num_o", cap_num, 16'd0);
		check_word("bank_laddr_o", cap_laddr, BANK_LADDR);
		check_word("bank_size_o", cap_size, 16'h2000);
		check_crt_data(base, 8192, 8'h5A);
		finish_test();
	endtask

	task automatic test_crt_data();
		int base;
		start_test("crt_data");
		// Two chips back to back
		base = log_addr.size();
		begin_download(IDX_CRT);
		check_bit("cart_attached_o", cart_attached_o, 1'b0);
		send_crt_header(16'h0013, 8'h00, 8'h00);
		send_chip(16'd0, 256, 8'hA7);
		send_chip(16'd1, 256, 8'hA7);
		end_download();
		check_word("bank_num_o", cap_num, 16'd1);
		check_crt_data(base, 512, 8'hA7);
		// A new download starts over at the base
		base = log_addr.size();
		begin_download(IDX_CRT);
		send_crt_header(16'h0000, 8'h00, 8'h01);
		send_chip(16'd0, 64, 8'hC3);
		end_download();
		check_bit("cart_attached_o", cart_attached_o, 1'b1);
		check_crt_data(base, 64, 8'hC3);
		finish_test();
	endtask

	//======================================
	// Test sequence
	//======================================
	initial begin
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_offset_i = '0;
		dl_data_i   = '0;
		dl_wr_i     = 1'b0;
		next_ofs    = '0;
		data_idx    = 0;
		wait (reset_n === 1'b1);
		@(negedge clk_sys);

		test_reset();
		test_prg_data();
		test_prg_pointers();
		test_crt_header();
		test_crt_data();

		if (dut0.u_mem_write_port.u_loader_sva.sva_fails != 0) begin
			errors++;
			$display("Bound assertions failed %0d times",
				dut0.u_mem_write_port.u_loader_sva.sva_fails);
		end
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
design/loader_pkg.sv
design/mem_write_port.sv
design/prg_loader.sv
design/crt_loader.sv
design/loader_top.sv
test/tb_clock.sv
test/loader_sva.sv
test/tb_top.sv

// ==== Bender.yml ====
package:
  name: home_loader

sources:
  # Loader RTL
  - design/loader_pkg.sv
  - design/mem_write_port.sv
  - design/prg_loader.sv
  - design/crt_loader.sv
  - design/loader_top.sv

  # Testbench
  - target: test
    files:
      - test/tb_clock.sv
      - test/loader_sva.sv
      - test/tb_top.sv
